/* all.f */
+incdir+source
source/dma_bus_pkg.sv
source/dma_core_pkg.sv
source/bus_arbiter.sv
source/transfer_buffer.sv
source/bus_memory_target.sv
source/dma_engine.sv
source/dma_subsystem.sv
dv/dma_subsystem_tb.sv

/* dv/dma_subsystem_tb.sv */
`timescale 1ns/1ns
`include "dma_params.svh"

module dma_subsystem_tb;
    import dma_bus_pkg::*;
    import dma_core_pkg::*;

    localparam int RANDOM_TRANSFERS = 280;
    localparam int TIMEOUT_CYCLES = 300 * 40;

    logic            clock;
    logic            reset;
    logic            command_valid;
    dma_command_t    command;
    logic            command_ready;
    logic            transfer_done;
    logic            transfer_error;
    logic            foreign_request;
    logic            foreign_granted;
    buffer_address_t host_address;
    logic            host_write;
    bus_word_t       host_write_data;
    bus_word_t       host_read_data;

    bus_word_t       buffer_model [`DMA_BUFFER_DEPTH];
    byte_enable_t    buffer_known [`DMA_BUFFER_DEPTH]; // lanes whose value the model knows
    bus_word_t       memory_model [`DMA_MEMORY_WORDS];
    byte_enable_t    memory_known [`DMA_MEMORY_WORDS];
    logic            foreign_enable;
    logic            dma_bus_active;
    int              cycle_count;
    int              accepted_count;
    int              completed_count;

    dma_subsystem i_dma_subsystem (
        .clock           (clock),
        .reset           (reset),
        .command_valid   (command_valid),
        .command         (command),
        .command_ready   (command_ready),
        .transfer_done   (transfer_done),
        .transfer_error  (transfer_error),
        .foreign_request (foreign_request),
        .foreign_granted (foreign_granted),
        .host_address    (host_address),
        .host_write      (host_write),
        .host_write_data (host_write_data),
        .host_read_data  (host_read_data)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("TEST FAILED");
            $fatal(1, "timeout after %0d cycles, a transfer never finished", cycle_count);
        end
    end

    // dma transaction in progress, from the begin strobe to the target's answer
    assign dma_bus_active = i_dma_subsystem.master_bus.begin_transaction ||
                            i_dma_subsystem.master_bus.data_valid ||
                            i_dma_subsystem.target_bus.busy ||
                            i_dma_subsystem.target_bus.data_valid ||
                            i_dma_subsystem.target_bus.error;

    always @(negedge clock) begin
        if (!reset) begin
            check_value("foreign_granted and dma bus phase",
                        bus_word_t'(foreign_granted && dma_bus_active), '0);
            check_value("foreign_granted and dma_granted",
                        bus_word_t'(foreign_granted && i_dma_subsystem.dma_granted), '0);
            completed_count += int'(transfer_done) + int'(transfer_error); // every pulse
        end
    end

    task automatic check_value(input string name, input bus_word_t actual,
                               input bus_word_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h",
                     $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic bus_word_t lane_mask(input byte_enable_t lanes);
        bus_word_t mask;
        for (int lane = 0; lane < 4; lane++) begin
            mask[lane*8 +: 8] = {8{lanes[lane]}};
        end
        return mask;
    endfunction

    function automatic bus_word_t window_address(input int word);
        return `DMA_MEMORY_BASE + bus_word_t'(word) * 4;
    endfunction

    function automatic bus_word_t outside_address();
        bus_word_t address;
        if ($urandom % 2 == 0) begin
            address = `DMA_MEMORY_BASE - 4 * bus_word_t'($urandom % 64 + 1); // below the base
        end else begin
            address = `DMA_MEMORY_BASE + `DMA_MEMORY_WORDS * 4 + 4 * bus_word_t'($urandom % 64);
        end
        return address;
    endfunction

    function automatic dma_command_t random_command();
        dma_command_t value;
        value.read_n_write = 1'($urandom);
        value.bus_address = $urandom;
        value.byte_enable = byte_enable_t'($urandom);
        value.buffer_address = buffer_address_t'($urandom);
        return value;
    endfunction

    task automatic next_cycle();
        @(negedge clock);
        foreign_request = foreign_enable && ($urandom % 3 == 0);
    endtask

    task automatic host_store(input buffer_address_t address, input bus_word_t data);
        host_address = address;
        host_write = 1'b1;
        host_write_data = data;
        next_cycle();
        host_write = 1'b0;
        buffer_model[address] = data;
        buffer_known[address] = 4'hf;
    endtask

    task automatic host_load(input buffer_address_t address, output bus_word_t data);
        host_address = address;
        next_cycle();
        data = host_read_data; // registered, one cycle after the address
    endtask

    task automatic run_command(input dma_command_t value, input logic expect_error);
        int done_count;
        int error_count;
        done_count = 0;
        error_count = 0;
        while (!command_ready) begin
            next_cycle();
        end
        command = value;
        command_valid = 1'b1;
        next_cycle();
        accepted_count++;
        check_value("command_ready", command_ready, '0); // engine left idle
        while (!command_ready) begin
            done_count += int'(transfer_done);
            error_count += int'(transfer_error);
            command = random_command(); // stray strobes while busy
            command_valid = ($urandom % 4) == 0;
            next_cycle();
        end
        command_valid = 1'b0;
        check_value("transfer_done count", done_count, expect_error ? 0 : 1);
        check_value("transfer_error count", error_count, expect_error ? 1 : 0);
    endtask

    task automatic do_transfer(input logic read_n_write, input bus_word_t bus_address,
                               input byte_enable_t byte_enable, input buffer_address_t index,
                               input logic expect_error);
        dma_command_t value;
        int           word;
        bus_word_t    readback;
        value.read_n_write = read_n_write;
        value.bus_address = bus_address;
        value.byte_enable = byte_enable;
        value.buffer_address = index;
        run_command(value, expect_error);
        if (!expect_error) begin
            word = int'((bus_address - `DMA_MEMORY_BASE) >> 2);
            if (read_n_write) begin
                buffer_model[index] = memory_model[word];
                buffer_known[index] = memory_known[word];
            end else begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (byte_enable[lane]) begin
                        memory_model[word][lane*8 +: 8] = buffer_model[index][lane*8 +: 8];
                        memory_known[word][lane] = buffer_known[index][lane];
                    end
                end
            end
        end
        host_load(index, readback);
        check_value("host_read_data", readback & lane_mask(buffer_known[index]),
                    buffer_model[index] & lane_mask(buffer_known[index]));
    endtask

    initial begin
        bus_word_t       readback;
        buffer_address_t index;
        int              word;
        int              choice;
        void'($urandom(71902));
        reset = 1'b1;
        command_valid = 1'b0;
        command = '0;
        foreign_request = 1'b0;
        foreign_enable = 1'b0;
        host_address = '0;
        host_write = 1'b0;
        host_write_data = '0;
        cycle_count = 0;
        accepted_count = 0;
        completed_count = 0;
        for (int i = 0; i < `DMA_MEMORY_WORDS; i++) begin
            memory_known[i] = 4'h0; // target memory starts unknown
        end
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        for (int i = 0; i < `DMA_BUFFER_DEPTH; i++) begin
            host_store(buffer_address_t'(i), $urandom);
        end
        for (int i = 0; i < `DMA_BUFFER_DEPTH; i++) begin
            host_load(buffer_address_t'(i), readback);
            check_value("host_read_data", readback, buffer_model[i]);
        end

        word = $urandom % `DMA_MEMORY_WORDS;
        host_store(9'd5, $urandom);
        do_transfer(1'b0, window_address(word), 4'hf, 9'd5, 1'b0);
        do_transfer(1'b1, window_address(word), 4'hf, 9'd9, 1'b0);
        host_store(9'd6, $urandom);
        do_transfer(1'b0, window_address(word), byte_enable_t'($urandom), 9'd6, 1'b0);
        do_transfer(1'b1, window_address(word), 4'hf, 9'd10, 1'b0);
        do_transfer(1'b1, outside_address(), 4'hf, 9'd11, 1'b1);
        do_transfer(1'b0, outside_address(), 4'hf, 9'd12, 1'b1);

        foreign_enable = 1'b1;
        for (int count = 0; count < RANDOM_TRANSFERS; count++) begin
            word = $urandom % 32; // narrow range so reads land on earlier writes
            choice = $urandom % 10;
            index = buffer_address_t'($urandom);
            if (choice == 0) begin
                do_transfer(1'($urandom), outside_address(), 4'hf, index, 1'b1);
            end else if (choice < 5) begin
                if ($urandom % 2 == 0) begin
                    host_store(index, $urandom);
                end
                do_transfer(1'b0, window_address(word), byte_enable_t'($urandom), index, 1'b0);
            end else begin
                do_transfer(1'b1, window_address(word), 4'hf, index, 1'b0);
            end
        end
        foreign_enable = 1'b0;
        next_cycle();
        @(posedge clock);

        check_value("completed transfers", completed_count, accepted_count);
        $display("TEST OK");
        $finish;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build the DMA subsystem testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f --top-module dma_subsystem_tb \
    -o dma_subsystem_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/dma_subsystem_sim
run_status=$?
if [ $run_status -ne 0 ]; then
    echo "simulation failed with status $run_status"
    exit $run_status
fi

exit 0

/* source/bus_arbiter.sv */
`timescale 1ns/1ns

module bus_arbiter (
    input  logic clock,
    input  logic reset,
    input  logic dma_request,
    input  logic foreign_request,
    output logic dma_granted,
    output logic foreign_granted
);

    logic dma_served_last;
    logic dma_hold;
    logic foreign_hold;
    logic pick_dma;
    logic pick_foreign;

    assign dma_hold = dma_granted && dma_request;
    assign foreign_hold = foreign_granted && foreign_request;

    // bus is free once neither owner keeps its request up
    always_comb begin
        pick_dma = 1'b0;
        pick_foreign = 1'b0;
        if (!dma_hold && !foreign_hold) begin
            if (dma_request && foreign_request) begin
                pick_dma = !dma_served_last;
                pick_foreign = dma_served_last;
            end else begin
                pick_dma = dma_request;
                pick_foreign = foreign_request;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            dma_granted <= 1'b0;
            foreign_granted <= 1'b0;
            dma_served_last <= 1'b0;
        end else begin
            dma_granted <= dma_hold || pick_dma;
            foreign_granted <= foreign_hold || pick_foreign;
            if (pick_dma) begin
                dma_served_last <= 1'b1;
            end else if (pick_foreign) begin
                dma_served_last <= 1'b0;
            end
        end
    end

endmodule

/* source/bus_memory_target.sv */
`timescale 1ns/1ns
`include "dma_params.svh"

module bus_memory_target (
    input  logic                     clock,
    input  logic                     reset,
    input  dma_bus_pkg::bus_master_t bus_in,
    output dma_bus_pkg::bus_target_t bus_out
);
    import dma_bus_pkg::*;

    localparam int INDEX_BITS = $clog2(`DMA_MEMORY_WORDS);
    localparam int COUNT_BITS = $clog2(`DMA_TARGET_WAIT_STATES + 2);

    typedef enum logic [1:0] {
        target_idle,
        target_wait,
        target_error
    } target_state_t;

    target_state_t         state;
    logic [COUNT_BITS-1:0] wait_count;
    bus_address_t          offset;
    logic                  in_window;
    logic [INDEX_BITS-1:0] word_index;
    byte_enable_t          lane_enable;
    logic                  read_n_write;
    bus_word_t             read_word;
    logic                  complete;
    bus_word_t             memory [`DMA_MEMORY_WORDS];

    // addresses below the base wrap to large offsets
    assign offset = bus_in.address_data - `DMA_MEMORY_BASE;
    assign in_window = offset < bus_address_t'(`DMA_MEMORY_WORDS * 4);
    assign complete = (state == target_wait) && (wait_count == '0);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= target_idle;
            wait_count <= '0;
        end else begin
            case (state)
                target_idle: begin
                    if (bus_in.begin_transaction) begin
                        if (in_window) begin
                            state <= target_wait;
                            wait_count <= COUNT_BITS'(`DMA_TARGET_WAIT_STATES);
                        end else begin
                            state <= target_error;
                        end
                    end
                end
                target_wait: begin
                    if (wait_count != '0) begin
                        wait_count <= wait_count - 1'b1;
                    end else begin
                        state <= target_idle;
                    end
                end
                default: begin
                    state <= target_idle; // error lasts one cycle
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == target_idle && bus_in.begin_transaction) begin
            word_index <= offset[INDEX_BITS+1:2];
            lane_enable <= bus_in.byte_enable;
            read_n_write <= bus_in.read_n_write;
            read_word <= memory[offset[INDEX_BITS+1:2]];
        end
        if (complete && !read_n_write && bus_in.data_valid && bus_in.end_transaction) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (lane_enable[lane]) begin
                    memory[word_index][lane*8 +: 8] <= bus_in.address_data[lane*8 +: 8];
                end
            end
        end
    end

    always_comb begin
        bus_out = '0;
        bus_out.busy = (state == target_wait) && (wait_count != '0);
        bus_out.error = (state == target_error);
        if (complete && read_n_write) begin
            bus_out.address_data = read_word;
            bus_out.data_valid = 1'b1;
            bus_out.end_transaction = 1'b1;
        end
    end

endmodule

/* source/dma_bus_pkg.sv */
package dma_bus_pkg;

    // one word on the multiplexed address/data lines
    typedef logic [31:0] bus_word_t;

    typedef logic [3:0] byte_enable_t; // one bit per byte lane

    // byte address as seen by a target
    typedef logic [31:0] bus_address_t;

    // driven by the bus master
    typedef struct packed {
        bus_word_t    address_data;
        byte_enable_t byte_enable;
        logic         read_n_write;      // 1 = read
        logic         begin_transaction;
        logic         end_transaction;
        logic         data_valid;
    } bus_master_t;

    // driven by the bus target
    typedef struct packed {
        bus_word_t address_data;
        logic      end_transaction;
        logic      data_valid;
        logic      busy;
        logic      error;
    } bus_target_t;

endpackage

/* source/dma_core_pkg.sv */
package dma_core_pkg;

    typedef logic [8:0] buffer_address_t; // word index into the transfer buffer

    // command from the ip core
    typedef struct packed {
        logic                     read_n_write; // 1 = bus to buffer
        dma_bus_pkg::bus_word_t   bus_address;
        dma_bus_pkg::byte_enable_t byte_enable;
        buffer_address_t          buffer_address;
    } dma_command_t;

    typedef enum logic [3:0] {
        idle,
        fetch_buffer,
        write_request,
        write_address,
        write_data,
        read_request,
        read_address,
        read_data,
        fill_buffer,
        finish
    } dma_state_t;

endpackage

/* source/dma_engine.sv */
`timescale 1ns/1ns

module dma_engine (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          command_valid,
    input  dma_core_pkg::dma_command_t    command,
    output logic                          command_ready,
    output logic                          transfer_done,
    output logic                          transfer_error,
    output dma_core_pkg::buffer_address_t buffer_address,
    output logic                          buffer_write,
    output dma_bus_pkg::bus_word_t        buffer_write_data,
    input  dma_bus_pkg::bus_word_t        buffer_read_data,
    output logic                          dma_request,
    input  logic                          dma_granted,
    output dma_bus_pkg::bus_master_t      bus_out,
    input  dma_bus_pkg::bus_target_t      bus_in
);
    import dma_bus_pkg::*;
    import dma_core_pkg::*;

    dma_state_t   state;
    dma_state_t   next_state;
    dma_command_t command_reg;
    bus_word_t    data_reg;   // word in flight between buffer and bus
    logic         bus_phase;

    // the target can only answer with an error after a begin strobe
    assign bus_phase = (state == write_address) || (state == write_data) ||
                       (state == read_address) || (state == read_data);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (command_valid) begin
                    next_state = command.read_n_write ? read_request : fetch_buffer;
                end
            end
            fetch_buffer:  next_state = write_request;
            write_request: if (dma_granted) next_state = write_address;
            write_address: next_state = write_data;
            write_data:    if (!bus_in.busy) next_state = finish; // target done waiting
            read_request:  if (dma_granted) next_state = read_address;
            read_address:  next_state = read_data;
            read_data:     if (bus_in.end_transaction) next_state = fill_buffer;
            fill_buffer:   next_state = finish;
            finish:        next_state = idle;
            default:       next_state = idle;
        endcase
        if (bus_phase && bus_in.error) begin
            next_state = idle;
        end
    end

    // command and payload words
    always_ff @(posedge clock) begin
        if (state == idle && command_valid) begin
            command_reg <= command;
        end
        if (state == write_request && dma_granted) begin
            data_reg <= buffer_read_data; // address has been stable since fetch_buffer
        end else if (state == read_data && bus_in.data_valid) begin
            data_reg <= bus_in.address_data;
        end
    end

    assign command_ready = (state == idle);
    assign transfer_done = (state == finish);
    assign transfer_error = bus_phase && bus_in.error;

    assign buffer_address = command_reg.buffer_address;
    assign buffer_write = (state == fill_buffer);
    assign buffer_write_data = data_reg;

    // held until finish so the grant covers the whole transfer
    assign dma_request = (state == write_request) || (state == write_address) ||
                         (state == write_data) || (state == read_request) ||
                         (state == read_address) || (state == read_data) ||
                         (state == fill_buffer);

    always_comb begin
        bus_out = '0;
        case (state)
            write_address, read_address: begin
                bus_out.address_data = command_reg.bus_address;
                bus_out.byte_enable = command_reg.byte_enable;
                bus_out.read_n_write = command_reg.read_n_write;
                bus_out.begin_transaction = 1'b1;
            end
            write_data: begin
                bus_out.address_data = data_reg;
                bus_out.data_valid = 1'b1;
                bus_out.end_transaction = !bus_in.busy && !bus_in.error;
            end
            default: begin
                bus_out = '0;
            end
        endcase
    end

endmodule

/* source/dma_params.svh */
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// memory window on the bus, byte address of the first word
`define DMA_MEMORY_BASE 32'h40000000
`define DMA_MEMORY_WORDS 256

// must agree with the width of buffer_address_t
`define DMA_BUFFER_DEPTH 512

// busy cycles before the target completes
`define DMA_TARGET_WAIT_STATES 2

`endif

/* source/dma_subsystem.sv */
`timescale 1ns/1ns

module dma_subsystem (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          command_valid,
    input  dma_core_pkg::dma_command_t    command,
    output logic                          command_ready,
    output logic                          transfer_done,
    output logic                          transfer_error,
    input  logic                          foreign_request,
    output logic                          foreign_granted,
    input  dma_core_pkg::buffer_address_t host_address,
    input  logic                          host_write,
    input  dma_bus_pkg::bus_word_t        host_write_data,
    output dma_bus_pkg::bus_word_t        host_read_data
);
    import dma_bus_pkg::*;
    import dma_core_pkg::*;

    buffer_address_t buffer_address;
    logic            buffer_write;
    bus_word_t       buffer_write_data;
    bus_word_t       buffer_read_data;
    logic            dma_request;
    logic            dma_granted;
    bus_master_t     master_bus;
    bus_target_t     target_bus;

    dma_engine i_dma_engine (
        .clock             (clock),
        .reset             (reset),
        .command_valid     (command_valid),
        .command           (command),
        .command_ready     (command_ready),
        .transfer_done     (transfer_done),
        .transfer_error    (transfer_error),
        .buffer_address    (buffer_address),
        .buffer_write      (buffer_write),
        .buffer_write_data (buffer_write_data),
        .buffer_read_data  (buffer_read_data),
        .dma_request       (dma_request),
        .dma_granted       (dma_granted),
        .bus_out           (master_bus),
        .bus_in            (target_bus)
    );

    // engine on port a, host on port b
    transfer_buffer i_transfer_buffer (
        .clock             (clock),
        .port_a_address    (buffer_address),
        .port_a_write      (buffer_write),
        .port_a_write_data (buffer_write_data),
        .port_a_read_data  (buffer_read_data),
        .port_b_address    (host_address),
        .port_b_write      (host_write),
        .port_b_write_data (host_write_data),
        .port_b_read_data  (host_read_data)
    );

    bus_arbiter i_bus_arbiter (
        .clock           (clock),
        .reset           (reset),
        .dma_request     (dma_request),
        .foreign_request (foreign_request),
        .dma_granted     (dma_granted),
        .foreign_granted (foreign_granted)
    );

    bus_memory_target i_bus_memory_target (
        .clock   (clock),
        .reset   (reset),
        .bus_in  (master_bus),
        .bus_out (target_bus)
    );

endmodule

/* source/transfer_buffer.sv */
`timescale 1ns/1ns
`include "dma_params.svh"

module transfer_buffer (
    input  logic                          clock,
    input  dma_core_pkg::buffer_address_t port_a_address,
    input  logic                          port_a_write,
    input  dma_bus_pkg::bus_word_t        port_a_write_data,
    output dma_bus_pkg::bus_word_t        port_a_read_data,
    input  dma_core_pkg::buffer_address_t port_b_address,
    input  logic                          port_b_write,
    input  dma_bus_pkg::bus_word_t        port_b_write_data,
    output dma_bus_pkg::bus_word_t        port_b_read_data
);
    import dma_bus_pkg::*;

    bus_word_t memory [`DMA_BUFFER_DEPTH];
    logic      port_b_blocked;

    // same word written from both sides, engine side wins
    assign port_b_blocked = port_a_write && (port_a_address == port_b_address);

    always_ff @(posedge clock) begin
        if (port_a_write) begin
            memory[port_a_address] <= port_a_write_data;
        end
        if (port_b_write && !port_b_blocked) begin
            memory[port_b_address] <= port_b_write_data;
        end
        port_a_read_data <= memory[port_a_address]; // old word on a collision
        port_b_read_data <= memory[port_b_address];
    end

endmodule
